//--- design/vp_input_pkg.sv
// Shared types and constants for the console input and timing front end, imported by all modules
package vp_input_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Joystick ports on the console
	localparam int NUM_PLAYERS = 2;
	// Keys on one numpad
	localparam int NUMPAD_W = 10;

	////////////////////////////////////////
	// Controller and key words
	////////////////////////////////////////

	// One raw controller word, all active high
	// Numpad bit 0 is key 1 ... bit 8 is key 9, bit 9 is key 0
	typedef struct packed {
		logic [NUMPAD_W-1:0] numpad;
		logic                reset;
		logic                action;
		logic                up;
		logic                down;
		logic                left;
		logic                right;
	} joy_raw_t;

	// Console lines of one player, active low
	typedef struct packed {
		logic up_n;
		logic down_n;
		logic left_n;
		logic right_n;
		logic action_n;
	} player_ctl_t;

	// PS/2 key event word from the host
	typedef struct packed {
		logic       toggle;   // flips on each new event
		logic       pressed;  // make = 1, break = 0
		logic       extended; // E0 prefix, not decoded
		logic [7:0] code;
	} ps2_key_t;

	// Key event towards the keyboard matrix
	typedef struct packed {
		logic       valid;    // single-cycle strobe
		logic       released;
		logic [7:0] ascii;
	} key_event_t;

endpackage

//--- design/clk_enable_gen.sv
// Divides clk_sys into CPU and video-chip clock-enable pulses, with NTSC or PAL divisors
module clk_enable_gen #(
	parameter int CPU_DIV_NTSC = 8,
	parameter int CPU_DIV_PAL  = 12,
	parameter int VDC_DIV_NTSC = 6,
	parameter int VDC_DIV_PAL  = 10
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Largest divisor sets the shared counter width
	localparam int MAX_CPU = (CPU_DIV_NTSC > CPU_DIV_PAL) ? CPU_DIV_NTSC : CPU_DIV_PAL;
	localparam int MAX_VDC = (VDC_DIV_NTSC > VDC_DIV_PAL) ? VDC_DIV_NTSC : VDC_DIV_PAL;
	localparam int MAX_DIV = (MAX_CPU > MAX_VDC) ? MAX_CPU : MAX_VDC;
	localparam int CNT_W   = $clog2(MAX_DIV);

	// Channel 0 is the CPU, channel 1 the video chip
	logic [1:0][CNT_W-1:0] cnt_q;
	logic [1:0][CNT_W-1:0] limit;
	logic [1:0]            en_q;

	// Wrap value follows the standard
	assign limit[0] = pal_i ? CNT_W'(CPU_DIV_PAL - 1) : CNT_W'(CPU_DIV_NTSC - 1);
	assign limit[1] = pal_i ? VDC_DIV_PAL[CNT_W-1:0] - 1'b1 : VDC_DIV_NTSC[CNT_W-1:0] - 1'b1;

	// Free-running counters, pulse on wrap
	// >= catches a counter already past a shorter new limit
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cnt_q <= '0;
			en_q  <= '0;
		end else begin
			for (int ch = 0; ch < 2; ch++) begin
				if (cnt_q[ch] >= limit[ch]) begin
					cnt_q[ch] <= '0;
					en_q[ch]  <= 1'b1;
				end else begin
					cnt_q[ch] <= cnt_q[ch] + 1'b1;
					en_q[ch]  <= 1'b0;
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

	// Enables are strobes, never two in a row
	a_cpu_en_strobe : assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o |=> !cpu_en_o);
	a_vdc_en_strobe : assert property (@(posedge clk_sys) disable iff (reset)
		vdc_en_o |=> !vdc_en_o);

endmodule

//--- design/joy_router.sv
// Registers both joystick words, applies the player swap and forms the two-player reset
module joy_router (
	input  logic                                                clk_sys,
	input  logic                                                reset,
	input  logic                                                swap_i,
	input  vp_input_pkg::joy_raw_t                              joy_a_i,
	input  vp_input_pkg::joy_raw_t                              joy_b_i,
	output vp_input_pkg::joy_raw_t [vp_input_pkg::NUM_PLAYERS-1:0] joy_o,
	output logic                                                console_res_n_o
);
	import vp_input_pkg::*;

	joy_raw_t [NUM_PLAYERS-1:0] joy_in;
	joy_raw_t [NUM_PLAYERS-1:0] joy_d;
	joy_raw_t [NUM_PLAYERS-1:0] joy_q;
	logic     [NUM_PLAYERS-1:0] res_req;
	logic                       res_n_q;

	// Entry 0 is port A
	assign joy_in = {joy_b_i, joy_a_i};

	// Swap reverses player order
	always_comb begin
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			joy_d[p]   = swap_i ? joy_in[NUM_PLAYERS-1-p] : joy_in[p];
			res_req[p] = joy_d[p].reset;
		end
	end

	// Console reset only when every player holds reset
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			joy_q   <= '0;
			res_n_q <= 1'b1;
		end else begin
			joy_q   <= joy_d;
			res_n_q <= ~&res_req;
		end
	end

	assign joy_o           = joy_q;
	assign console_res_n_o = res_n_q;

endmodule

//--- design/player_port.sv
// Decodes one routed joystick word into console lines and a numpad key event
module player_port (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  vp_input_pkg::joy_raw_t   joy_i,
	output vp_input_pkg::player_ctl_t ctl_o,
	output vp_input_pkg::key_event_t key_o
);
	import vp_input_pkg::*;

	localparam logic [7:0] ASCII_ZERO = 8'h30;
	localparam logic [7:0] ASCII_ONE  = 8'h31;

	player_ctl_t         ctl_q;
	key_event_t          key_q;
	logic [NUMPAD_W-1:0] pad_prev_q;
	logic                pad_empty;

	////////////////////////////////////////
	// Numpad digit
	////////////////////////////////////////

	// Lowest set key wins
	// Bits 0..8 give 1..9, bit 9 gives 0
	function automatic logic [7:0] lowest_digit(input logic [NUMPAD_W-1:0] pad);
		logic [7:0] code;
		code = 8'h00;
		for (int i = NUMPAD_W - 1; i >= 0; i--) begin
			if (pad[i]) begin
				code = (i == NUMPAD_W - 1) ? ASCII_ZERO : ASCII_ONE + 8'(i);
			end
		end
		return code;
	endfunction

	assign pad_empty = (joy_i.numpad == '0);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ctl_q      <= '1;
			key_q      <= '{valid: 1'b0, released: 1'b1, ascii: 8'h00};
			pad_prev_q <= '0;
		end else begin
			// Console lines are active low
			ctl_q.up_n     <= ~joy_i.up;
			ctl_q.down_n   <= ~joy_i.down;
			ctl_q.left_n   <= ~joy_i.left;
			ctl_q.right_n  <= ~joy_i.right;
			ctl_q.action_n <= ~joy_i.action;

			// Event on any numpad bit change
			pad_prev_q     <= joy_i.numpad;
			key_q.valid    <= (joy_i.numpad != pad_prev_q);
			key_q.released <= pad_empty;
			// Code kept while nothing held
			if (!pad_empty) begin
				key_q.ascii <= lowest_digit(joy_i.numpad);
			end
		end
	end

	assign ctl_o = ctl_q;
	assign key_o = key_q;

	// A strobe means the numpad at the input really moved
	// Right after reset the previous numpad counts as empty
	a_pad_change : assert property (@(posedge clk_sys) disable iff (reset)
		key_q.valid |-> $past(joy_i.numpad) !=
			($past(reset, 2) ? '0 : $past(joy_i.numpad, 2)));

endmodule

//--- design/key_event_merge.sv
// Decodes PS/2 scan codes to console ASCII and merges them with numpad events into one stream
module key_event_merge (
	input  logic                                                  clk_sys,
	input  logic                                                  reset,
	input  vp_input_pkg::ps2_key_t                                ps2_key_i,
	input  vp_input_pkg::key_event_t [vp_input_pkg::NUM_PLAYERS-1:0] pkey_i,
	output vp_input_pkg::key_event_t                              key_o
);
	import vp_input_pkg::*;

	logic                   toggle_q;
	logic                   ps2_new_q;
	logic                   ps2_break_q;
	logic [7:0]             ps2_ascii_q;
	logic                   ps2_event;
	logic                   any_valid;
	logic [7:0]             win_ascii;
	logic [NUM_PLAYERS-1:0] pad_released;
	key_event_t             key_q;

	////////////////////////////////////////
	// Scan code table
	////////////////////////////////////////

	// Set 2 codes, extended bit not looked at
	function automatic logic [7:0] ps2_to_ascii(input logic [7:0] code);
		case (code)
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			// Yes / no keys of the console
			8'h1F: return 8'h11;
			8'h27: return 8'h12;
			8'h5A: return 8'h0A; // enter
			8'h66: return 8'h08; // backspace
			default: return 8'h00;
		endcase
	endfunction

	////////////////////////////////////////
	// PS/2 edge stage
	////////////////////////////////////////

	// New event whenever toggle flips
	assign ps2_event = (ps2_key_i.toggle != toggle_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q    <= 1'b0;
			ps2_new_q   <= 1'b0;
			ps2_break_q <= 1'b1;
		end else begin
			toggle_q  <= ps2_key_i.toggle;
			ps2_new_q <= ps2_event;
			if (ps2_event) begin
				ps2_break_q <= ~ps2_key_i.pressed;
			end
		end
	end

	// Decoded code, loaded per event
	always_ff @(posedge clk_sys) begin
		if (ps2_event) begin
			ps2_ascii_q <= ps2_to_ascii(ps2_key_i.code);
		end
	end

	////////////////////////////////////////
	// Arbiter
	////////////////////////////////////////

	// Fixed order PS/2, player 0, player 1
	// Losers dropped, no retry
	always_comb begin
		any_valid = 1'b0;
		win_ascii = key_q.ascii;
		for (int p = NUM_PLAYERS - 1; p >= 0; p--) begin
			pad_released[p] = pkey_i[p].released;
			if (pkey_i[p].valid) begin
				any_valid = 1'b1;
				win_ascii = pkey_i[p].ascii;
			end
		end
		if (ps2_new_q) begin
			any_valid = 1'b1;
			win_ascii = ps2_ascii_q;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_q <= '{valid: 1'b0, released: 1'b1, ascii: 8'h00};
		end else begin
			key_q.valid    <= any_valid;
			key_q.ascii    <= win_ascii;
			// Released only when nothing is held anywhere
			key_q.released <= ps2_break_q & (&pad_released);
		end
	end

	assign key_o = key_q;

	// No key strobe may leak out while the console is held in reset
	a_quiet_in_reset : assert property (@(posedge clk_sys) reset |-> !key_o.valid);

endmodule

//--- design/vp_input_top.sv
// Top of the console input front end, wiring clock enables, joystick routing and key merge
module vp_input_top #(
	parameter int CPU_DIV_NTSC = 8,
	parameter int CPU_DIV_PAL  = 12,
	parameter int VDC_DIV_NTSC = 6,
	parameter int VDC_DIV_PAL  = 10
) (
	input  logic                                                   clk_sys,
	input  logic                                                   reset,
	input  logic                                                   pal_i,
	input  logic                                                   swap_i,
	input  vp_input_pkg::joy_raw_t                                 joy_a_i,
	input  vp_input_pkg::joy_raw_t                                 joy_b_i,
	input  vp_input_pkg::ps2_key_t                                 ps2_key_i,
	output logic                                                   cpu_en_o,
	output logic                                                   vdc_en_o,
	output vp_input_pkg::player_ctl_t [vp_input_pkg::NUM_PLAYERS-1:0] ctl_o,
	output logic                                                   console_res_n_o,
	output vp_input_pkg::key_event_t                               key_o
);
	import vp_input_pkg::*;

	joy_raw_t   [NUM_PLAYERS-1:0] joy_routed;
	key_event_t [NUM_PLAYERS-1:0] pad_key;

	// CPU and video-chip enables
	clk_enable_gen #(
		.CPU_DIV_NTSC (CPU_DIV_NTSC),
		.CPU_DIV_PAL  (CPU_DIV_PAL),
		.VDC_DIV_NTSC (VDC_DIV_NTSC),
		.VDC_DIV_PAL  (VDC_DIV_PAL)
	) u_clk_enable_gen (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	// Player order and two-player reset
	joy_router u_joy_router (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.swap_i          (swap_i),
		.joy_a_i         (joy_a_i),
		.joy_b_i         (joy_b_i),
		.joy_o           (joy_routed),
		.console_res_n_o (console_res_n_o)
	);

	// One decoder per joystick port
	for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
		player_port u_player_port (
			.clk_sys (clk_sys),
			.reset   (reset),
			.joy_i   (joy_routed[p]),
			.ctl_o   (ctl_o[p]),
			.key_o   (pad_key[p])
		);
	end

	// Keyboard and numpads into one stream
	key_event_merge u_key_event_merge (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_key_i (ps2_key_i),
		.pkey_i    (pad_key),
		.key_o     (key_o)
	);

endmodule

//--- sim/clk_gen.sv
// Testbench clock and power-on reset source, instantiated once by the testbench top
module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free-running system clock
	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Reset held for a few cycles, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

//--- sim/tb_vp_input.sv
// Random-stimulus testbench for the input front end, checked every cycle against a reference model
module tb_vp_input;
	timeunit 1ns;
	timeprecision 1ps;
	import vp_input_pkg::*;

	localparam int CPU_DIV_NTSC   = 8;
	localparam int CPU_DIV_PAL    = 12;
	localparam int VDC_DIV_NTSC   = 6;
	localparam int VDC_DIV_PAL    = 10;
	localparam int NUM_CYCLES     = 3000;
	localparam int PAL_ON_CYCLE   = 1000;
	localparam int PAL_OFF_CYCLE  = 2000;
	// Run length plus a third for margin
	localparam int TIMEOUT_CYCLES = (NUM_CYCLES * 4) / 3;
	localparam logic [31:0] SEED  = 32'h3a8e84a7;

	// Scan code table, digits 1..9 then 0, letters a..z
	localparam logic [7:0] DIGIT_CODES [10] = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
		8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45};
	localparam logic [7:0] LETTER_CODES [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24,
		8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D,
		8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
	// Symbols and control keys, code and character side by side
	localparam logic [7:0] SYM_CODES [10] = '{8'h29, 8'h79, 8'h7B, 8'h7C, 8'h4A,
		8'h55, 8'h1F, 8'h27, 8'h5A, 8'h66};
	localparam logic [7:0] SYM_CHARS [10] = '{8'h20, 8'h2B, 8'h2D, 8'h2A, 8'h2F,
		8'h3D, 8'h11, 8'h12, 8'h0A, 8'h08};

	logic                          clk_sys;
	logic                          reset;
	logic                          pal_i;
	logic                          swap_i;
	joy_raw_t                      joy_a;
	joy_raw_t                      joy_b;
	ps2_key_t                      ps2_key;
	logic                          cpu_en;
	logic                          vdc_en;
	player_ctl_t [NUM_PLAYERS-1:0] ctl;
	logic                          res_n;
	key_event_t                    key;
	int                            cycle_count = 0;

	// Reference model state
	int          m_cpu_cnt;
	int          m_vdc_cnt;
	logic        m_cpu_en;
	logic        m_vdc_en;
	joy_raw_t    m_route [NUM_PLAYERS];
	logic        m_res_n;
	player_ctl_t m_ctl [NUM_PLAYERS];
	logic [9:0]  m_pad_prev [NUM_PLAYERS];
	logic        m_pvalid [NUM_PLAYERS];
	logic        m_prel [NUM_PLAYERS];
	logic [7:0]  m_pascii [NUM_PLAYERS];
	logic        m_tog;
	logic        m_ps2_new;
	logic        m_ps2_brk;
	logic [7:0]  m_ps2_char;
	logic        m_key_valid;
	logic        m_key_rel;
	logic [7:0]  m_key_ascii;

	clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clk_gen (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	vp_input_top #(
		.CPU_DIV_NTSC (CPU_DIV_NTSC),
		.CPU_DIV_PAL  (CPU_DIV_PAL),
		.VDC_DIV_NTSC (VDC_DIV_NTSC),
		.VDC_DIV_PAL  (VDC_DIV_PAL)
	) DUT (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pal_i           (pal_i),
		.swap_i          (swap_i),
		.joy_a_i         (joy_a),
		.joy_b_i         (joy_b),
		.ps2_key_i       (ps2_key),
		.cpu_en_o        (cpu_en),
		.vdc_en_o        (vdc_en),
		.ctl_o           (ctl),
		.console_res_n_o (res_n),
		.key_o           (key)
	);

	////////////////////////////////////////
	// Model helpers
	////////////////////////////////////////

	// Scan code to console character, 00h if unknown
	function automatic logic [7:0] code_to_char(input logic [7:0] code);
		logic [7:0] ch;
		ch = 8'h00;
		for (int i = 0; i < 10; i++) begin
			if (code == DIGIT_CODES[i])
				ch = (i == 9) ? 8'h30 : 8'h31 + 8'(i);
			if (code == SYM_CODES[i])
				ch = SYM_CHARS[i];
		end
		for (int i = 0; i < 26; i++) begin
			if (code == LETTER_CODES[i])
				ch = 8'h61 + 8'(i);
		end
		return ch;
	endfunction

	// Digit of the lowest pressed numpad key
	function automatic logic [7:0] numpad_digit(input logic [9:0] pad);
		int idx;
		idx = 0;
		while (idx < 9 && !pad[idx])
			idx++;
		return (idx == 9) ? 8'h30 : 8'h31 + 8'(idx);
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	always @(posedge clk_sys or posedge reset) begin : model_step
		int         cpu_lim;
		int         vdc_lim;
		logic       ps2_ev;
		logic       won;
		logic [7:0] won_char;
		logic       all_rel;
		if (reset) begin
			m_cpu_cnt   <= 0;
			m_vdc_cnt   <= 0;
			m_cpu_en    <= 1'b0;
			m_vdc_en    <= 1'b0;
			m_res_n     <= 1'b1;
			m_tog       <= 1'b0;
			m_ps2_new   <= 1'b0;
			m_ps2_brk   <= 1'b1;
			m_ps2_char  <= 8'h00;
			m_key_valid <= 1'b0;
			m_key_rel   <= 1'b1;
			m_key_ascii <= 8'h00;
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				m_route[p]    <= '0;
				m_ctl[p]      <= '1;
				m_pad_prev[p] <= '0;
				m_pvalid[p]   <= 1'b0;
				m_prel[p]     <= 1'b1;
				m_pascii[p]   <= 8'h00;
			end
		end else begin
			// Enables pulse on wrap, new standard seen at once
			cpu_lim = (pal_i ? CPU_DIV_PAL : CPU_DIV_NTSC) - 1;
			vdc_lim = (pal_i ? VDC_DIV_PAL : VDC_DIV_NTSC) - 1;
			m_cpu_en  <= (m_cpu_cnt >= cpu_lim);
			m_cpu_cnt <= (m_cpu_cnt >= cpu_lim) ? 0 : m_cpu_cnt + 1;
			m_vdc_en  <= (m_vdc_cnt >= vdc_lim);
			m_vdc_cnt <= (m_vdc_cnt >= vdc_lim) ? 0 : m_vdc_cnt + 1;

			// Router stage
			m_route[0] <= swap_i ? joy_b : joy_a;
			m_route[1] <= swap_i ? joy_a : joy_b;
			m_res_n    <= !(joy_a.reset && joy_b.reset);

			// Player stage, one cycle behind the router
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				m_ctl[p].up_n     <= ~m_route[p].up;
				m_ctl[p].down_n   <= ~m_route[p].down;
				m_ctl[p].left_n   <= ~m_route[p].left;
				m_ctl[p].right_n  <= ~m_route[p].right;
				m_ctl[p].action_n <= ~m_route[p].action;
				m_pad_prev[p]     <= m_route[p].numpad;
				m_pvalid[p]       <= (m_route[p].numpad != m_pad_prev[p]);
				m_prel[p]         <= (m_route[p].numpad == '0);
				if (m_route[p].numpad != '0)
					m_pascii[p] <= numpad_digit(m_route[p].numpad);
			end

			// PS/2 edge stage
			ps2_ev = (ps2_key.toggle != m_tog);
			m_tog     <= ps2_key.toggle;
			m_ps2_new <= ps2_ev;
			if (ps2_ev) begin
				m_ps2_brk  <= ~ps2_key.pressed;
				m_ps2_char <= code_to_char(ps2_key.code);
			end

			// Winner in order PS/2, player 0, player 1
			won      = m_ps2_new;
			won_char = m_ps2_char;
			all_rel  = m_ps2_brk;
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				if (!won && m_pvalid[p]) begin
					won      = 1'b1;
					won_char = m_pascii[p];
				end
				all_rel = all_rel && m_prel[p];
			end
			m_key_valid <= won;
			m_key_rel   <= all_rel;
			if (won)
				m_key_ascii <= won_char;
		end
	end

	////////////////////////////////////////
	// Checks and stimulus
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error %s: got %h, expected %h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic compare_outputs();
		check_value("cpu_en_o", 32'(cpu_en), 32'(m_cpu_en));
		check_value("vdc_en_o", 32'(vdc_en), 32'(m_vdc_en));
		check_value("console_res_n_o", 32'(res_n), 32'(m_res_n));
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			check_value($sformatf("ctl_o[%0d]", p), 32'(ctl[p]), 32'(m_ctl[p]));
		end
		check_value("key_o.valid", 32'(key.valid), 32'(m_key_valid));
		check_value("key_o.released", 32'(key.released), 32'(m_key_rel));
		check_value("key_o.ascii", 32'(key.ascii), 32'(m_key_ascii));
	endtask

	// Sparse bit flips on a joystick word
	function automatic logic [15:0] flip_mask();
		logic [15:0] mask;
		mask = '0;
		for (int b = 0; b < 16; b++) begin
			if ($urandom_range(0, 47) == 0)
				mask[b] = 1'b1;
		end
		return mask;
	endfunction

	// Mostly table codes, some arbitrary bytes
	function automatic logic [7:0] pick_code();
		int unsigned sel;
		sel = $urandom_range(0, 59);
		if (sel < 10)
			return DIGIT_CODES[sel];
		if (sel < 36)
			return LETTER_CODES[sel - 10];
		if (sel < 46)
			return SYM_CODES[sel - 36];
		return 8'($urandom);
	endfunction

	task automatic drive_inputs(input int cyc);
		if (cyc == PAL_ON_CYCLE || cyc == PAL_OFF_CYCLE)
			pal_i = ~pal_i;
		if ($urandom_range(0, 99) == 0)
			swap_i = ~swap_i;
		joy_a = joy_a ^ flip_mask();
		joy_b = joy_b ^ flip_mask();
		// Now and then a player lets go of the whole numpad
		if ($urandom_range(0, 15) == 0)
			joy_a.numpad = '0;
		if ($urandom_range(0, 15) == 0)
			joy_b.numpad = '0;
		// New PS/2 event now and then
		if ($urandom_range(0, 7) == 0) begin
			ps2_key.toggle   = ~ps2_key.toggle;
			ps2_key.pressed  = 1'($urandom_range(0, 1));
			ps2_key.extended = 1'($urandom_range(0, 1));
			ps2_key.code     = pick_code();
		end
	endtask

	// Watchdog
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run never finished within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "Stopped by the watchdog");
		end
	end

	initial begin
		pal_i    = 1'b0;
		swap_i   = 1'b0;
		joy_a    = '0;
		joy_b    = '0;
		ps2_key  = '0;
		void'($urandom(SEED));
		// Compare on the falling edge, then drive the next inputs
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
			@(negedge clk_sys);
			compare_outputs();
			drive_inputs(cyc);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- vlog.f
design/vp_input_pkg.sv
design/clk_enable_gen.sv
design/joy_router.sv
design/player_port.sv
design/key_event_merge.sv
design/vp_input_top.sv
sim/clk_gen.sv
sim/tb_vp_input.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_vp_input -o tb_vp_input
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_vp_input > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
echo "Simulation finished without failures"
exit 0
